// File: source/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry, two ways
// 16 sets of 16-byte lines

// set index bits
`define ICACHE_INDEX_W  4

// byte offset inside a line
`define ICACHE_OFFSET_W 4

// tag bits, what is left of the address
`define ICACHE_TAG_W    24

// one line, also one memory beat
`define ICACHE_LINE_W   128

// fetch address, physical equals virtual
`define ICACHE_ADDR_W   32

`endif

// File: source/icache_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // fetch address as the pipeline sees it
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic                       dw_sel;    // which doubleword of the line
        logic                       word_sel;  // word inside the doubleword
        logic [1:0]                 byte_off;  // nonzero means misaligned
    } fetch_view_t;

    // operand of a cache operation, same word
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    unused;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-2:0] rsvd;
        logic                        way_sel;   // way for store-tag / index-inv
    } cacop_view_t;

    typedef union packed {
        fetch_view_t fetch;
        cacop_view_t cacop;
    } req_word_u;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08  // fetch address error
    } exc_code_e;

    typedef enum logic [1:0] {
        CACOP_STORE_TAG = 2'b00,
        CACOP_INDEX_INV = 2'b01,
        CACOP_HIT_INV   = 2'b10
    } cacop_e;

endpackage

`default_nettype wire

// File: source/icache_if.sv
`default_nettype none

`include "icache_defines.svh"

// buffered request from decode, handshake back from execute
interface icache_req_if;
    logic                  pending;     // buffered request has work for execute
    icache_pkg::req_word_u req_word;
    logic                  is_uncache;
    logic                  is_cacop;
    icache_pkg::cacop_e    cacop_code;
    icache_pkg::exc_code_e exc;
    logic                  accept_hint; // a fetch is offered, no cacop ahead of it
    logic                  take;        // load request buffer this cycle
    logic                  lookup_hit;
    logic                  way_hit;     // way number of the hit

    modport decode_mp (
        output pending, req_word, is_uncache, is_cacop, cacop_code, exc, accept_hint,
        input  take, lookup_hit
    );
    modport execute_mp (
        input  pending, req_word, is_uncache, is_cacop, cacop_code, exc, accept_hint,
        output take, lookup_hit, way_hit
    );
endinterface

// line to answer from, plus request info for the result stage
interface icache_line_if;
    logic                      line_valid;
    logic [`ICACHE_LINE_W-1:0] line_data;
    logic                      from_refill;
    icache_pkg::req_word_u     pc;
    icache_pkg::exc_code_e     exc;
    logic                      issue;       // new fetch accepted
    logic                      cacop_state; // execute is in its cacop cycle

    modport execute_mp (
        output line_valid, line_data, from_refill, pc, exc, issue, cacop_state
    );
    modport result_mp (input line_valid, line_data, from_refill, pc, exc, issue);
endinterface

`default_nettype wire

// File: source/icache_decode.sv
`default_nettype none

`include "icache_defines.svh"

module icache_decode (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_rvalid,
    input  logic [`ICACHE_ADDR_W-1:0] i_raddr,
    input  logic                      i_uncache,
    input  logic                      i_cacop_en,
    input  icache_pkg::cacop_e        i_cacop_code,
    icache_req_if.decode_mp           req
);
    icache_pkg::req_word_u word_q;
    icache_pkg::cacop_e    code_q;
    logic                  uncache_q;
    logic                  fetch_q;   // buffer holds a fetch
    logic                  cacop_q;   // buffer holds a cache operation

    // cacop wins over a fetch offered in the same cycle
    assign req.accept_hint = i_rvalid && !i_cacop_en;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetch_q <= 1'b0;
            cacop_q <= 1'b0;
        end else if (req.take) begin
            fetch_q <= req.accept_hint;
            cacop_q <= i_cacop_en;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (req.take) begin
            word_q    <= i_raddr;
            uncache_q <= i_uncache;
            code_q    <= i_cacop_code;
        end
    end

    assign req.req_word   = word_q;
    assign req.is_uncache = uncache_q;
    assign req.is_cacop   = cacop_q;
    assign req.cacop_code = code_q;

    // only fetches can be misaligned
    assign req.exc = (fetch_q && word_q.fetch.byte_off != 2'b00) ? icache_pkg::EXC_ADEF
                                                                 : icache_pkg::EXC_NONE;

    // hit-invalidate only has work when the tag matched
    always_comb begin
        if (cacop_q) begin
            req.pending = (code_q != icache_pkg::CACOP_HIT_INV) || req.lookup_hit;
        end else begin
            req.pending = fetch_q;
        end
    end

endmodule

`default_nettype wire

// File: source/icache_execute.sv
`default_nettype none

`include "icache_defines.svh"

module icache_execute (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_rvalid,
    input  logic                       i_cacop_en,
    input  logic [`ICACHE_INDEX_W-1:0] i_raddr_index,
    input  logic                       i_mem_rready,
    input  logic [`ICACHE_LINE_W-1:0]  i_mem_rdata,
    output logic                       o_mem_rvalid,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_raddr,
    output logic                       o_idle,
    icache_req_if.execute_mp           req,
    icache_line_if.execute_mp          line
);
    localparam int SETS = 1 << `ICACHE_INDEX_W;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4
    } state_e;

    state_e state;
    state_e next_state;

    // storage, index [way][set]
    logic [`ICACHE_TAG_W-1:0]  tag_mem  [2][SETS];
    logic [`ICACHE_LINE_W-1:0] data_mem [2][SETS];
    logic [SETS-1:0]           valid_q  [2];
    logic [SETS-1:0]           lru_q;        // most recently used way per set

    // registered array read, taken at acceptance
    logic [`ICACHE_TAG_W-1:0]  tag_rd  [2];
    logic [`ICACHE_LINE_W-1:0] data_rd [2];
    logic [1:0]                valid_rd;

    logic [`ICACHE_LINE_W-1:0] ret_buf;      // line returned by memory

    logic [`ICACHE_INDEX_W-1:0] idx;
    logic [1:0]                 hit;
    logic                       answer;
    logic                       hit_ans;
    logic                       fill;
    logic                       victim;
    logic                       clr_way;
    logic                       clr_en;

    assign idx = req.req_word.fetch.index;  // same bits in the cacop view

    assign hit[0] = valid_rd[0] && (tag_rd[0] == req.req_word.fetch.tag);
    assign hit[1] = valid_rd[1] && (tag_rd[1] == req.req_word.fetch.tag);
    assign req.lookup_hit = |hit;
    assign req.way_hit    = hit[1];

    // lookup answers right away on an address error or a cached hit
    assign answer  = (state == LOOKUP) && req.pending &&
                     ((req.exc != icache_pkg::EXC_NONE) ||
                      (!req.is_uncache && req.lookup_hit));
    assign hit_ans = answer && (req.exc == icache_pkg::EXC_NONE);

    assign req.take   = (state == IDLE) || answer;  // hits run back to back
    assign line.issue = req.take && req.accept_hint;

    assign victim = ~lru_q[idx];
    assign fill   = (state == MISS) && i_mem_rready && !req.is_uncache;

    // way to clear for a cache operation
    assign clr_way = (req.cacop_code == icache_pkg::CACOP_HIT_INV) ? req.way_hit
                                                                   : req.req_word.cacop.way_sel;
    assign clr_en  = (state == CACOP) && req.is_cacop && req.pending;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_cacop_en) begin
                    next_state = CACOP;
                end else if (i_rvalid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (answer) begin
                    next_state = req.accept_hint ? LOOKUP : IDLE;
                end else begin
                    next_state = MISS;  // cached miss or uncached
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    next_state = REFILL;
                end
            end
            REFILL:  next_state = IDLE;
            CACOP:   next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            state <= next_state;
            if (hit_ans) begin
                lru_q[idx] <= req.way_hit;
            end
            if (fill) begin
                valid_q[victim][idx] <= 1'b1;
                lru_q[idx]           <= victim;  // new line counts as used
            end
            if (clr_en) begin
                valid_q[clr_way][idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == MISS) && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
        if (fill) begin
            tag_mem[victim][idx]  <= req.req_word.fetch.tag;
            data_mem[victim][idx] <= i_mem_rdata;
        end
        if (req.take) begin
            for (int w = 0; w < 2; w++) begin
                tag_rd[w]   <= tag_mem[w][i_raddr_index];
                data_rd[w]  <= data_mem[w][i_raddr_index];
                valid_rd[w] <= valid_q[w][i_raddr_index];
            end
        end
    end

    assign line.from_refill = (state == REFILL);
    assign line.line_valid  = answer || line.from_refill;
    assign line.line_data   = line.from_refill ? ret_buf : data_rd[req.way_hit];
    assign line.pc          = req.req_word;
    assign line.exc         = req.exc;
    assign line.cacop_state = (state == CACOP);

    assign o_mem_rvalid = (state == MISS);  // held through back-pressure
    assign o_mem_raddr  = req.req_word;     // memory aligns to the line
    assign o_idle       = (state == IDLE);

endmodule

`default_nettype wire

// File: source/icache_result.sv
`default_nettype none

`include "icache_defines.svh"

module icache_result (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_flush,
    output logic                      o_rready,
    output logic [63:0]               o_rdata,
    output logic [`ICACHE_ADDR_W-1:0] o_pc,
    output icache_pkg::exc_code_e     o_exception,
    output logic [`ICACHE_ADDR_W-1:0] o_badv,
    icache_line_if.result_mp          line
);
    localparam int HALF = `ICACHE_LINE_W / 2;

    logic flush_valid;  // request in flight not yet flushed

    // flush wins over a new issue in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            flush_valid <= 1'b0;
        end else if (line.issue) begin
            flush_valid <= 1'b1;
        end
    end

    // a flush in the answer cycle also cancels it
    assign o_rready = line.line_valid && flush_valid && !i_flush;

    // pc bit 3 picks the doubleword
    always_comb begin
        if (line.pc.fetch.dw_sel) begin
            o_rdata = line.line_data[`ICACHE_LINE_W-1:HALF];
        end else begin
            o_rdata = line.line_data[HALF-1:0];
        end
    end

    assign o_pc = line.pc;

    // refills come only from aligned fetches
    assign o_exception = line.from_refill ? icache_pkg::EXC_NONE : line.exc;

    always_comb begin
        if (o_exception != icache_pkg::EXC_NONE) begin
            o_badv = line.pc;
        end else begin
            o_badv = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/icache_top.sv
`default_nettype none

`include "icache_defines.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rstn,

    // fetch pipeline
    input  logic                      i_rvalid,
    input  logic [`ICACHE_ADDR_W-1:0] i_raddr,
    input  logic                      i_uncache,
    input  logic                      i_flush,
    output logic                      o_rready,
    output logic [63:0]               o_rdata,
    output logic [`ICACHE_ADDR_W-1:0] o_pc,
    output icache_pkg::exc_code_e     o_exception,
    output logic [`ICACHE_ADDR_W-1:0] o_badv,
    output logic                      o_idle,

    // cache operations
    input  logic                      i_cacop_en,
    input  icache_pkg::cacop_e        i_cacop_code,
    output logic                      o_cacop_done,

    // memory port, one line per request
    output logic                      o_mem_rvalid,
    output logic [`ICACHE_ADDR_W-1:0] o_mem_raddr,
    input  logic                      i_mem_rready,
    input  logic [`ICACHE_LINE_W-1:0] i_mem_rdata
);
    icache_req_if  req_bus ();
    icache_line_if line_bus ();

    icache_decode u_decode (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_raddr      (i_raddr),
        .i_uncache    (i_uncache),
        .i_cacop_en   (i_cacop_en),
        .i_cacop_code (i_cacop_code),
        .req          (req_bus)
    );

    icache_execute u_execute (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_cacop_en    (i_cacop_en),
        .i_raddr_index (i_raddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]),  // array read index
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata),
        .o_mem_rvalid  (o_mem_rvalid),
        .o_mem_raddr   (o_mem_raddr),
        .o_idle        (o_idle),
        .req           (req_bus),
        .line          (line_bus)
    );

    icache_result u_result (
        .clk         (clk),
        .rstn        (rstn),
        .i_flush     (i_flush),
        .o_rready    (o_rready),
        .o_rdata     (o_rdata),
        .o_pc        (o_pc),
        .o_exception (o_exception),
        .o_badv      (o_badv),
        .line        (line_bus)
    );

    // done in the single cacop cycle
    assign o_cacop_done = line_bus.cacop_state;

endmodule

`default_nettype wire

// File: dv/icache_mem_model.sv
`default_nettype none

`include "icache_defines.svh"

// line memory behind the cache, one 128-bit beat per request
module icache_mem_model (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_rvalid,
    input  logic [`ICACHE_ADDR_W-1:0] i_raddr,
    output logic                      o_rready,
    output logic [`ICACHE_LINE_W-1:0] o_rdata,
    output int                        o_count     // requests seen so far
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                      busy;
    int                        delay;
    logic [`ICACHE_ADDR_W-1:0] base;

    // every word differs, odd multiplier keeps it one to one
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
    endfunction

    initial begin
        o_rready = 1'b0;
        o_rdata  = '0;
        o_count  = 0;
        busy     = 1'b0;
        delay    = 0;
    end

    always @(posedge clk) begin
        #1;
        if (!rstn) begin
            busy     = 1'b0;
            o_rready = 1'b0;
            o_count  = 0;
        end else if (o_rready) begin
            o_rready = 1'b0;  // single beat
        end else if (busy) begin
            if (delay == 0) begin
                base     = {i_raddr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], 4'h0};
                o_rdata  = {word_at(base + 32'd12), word_at(base + 32'd8),
                            word_at(base + 32'd4), word_at(base)};
                o_rready = 1'b1;
                busy     = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end else if (i_rvalid) begin
            busy    = 1'b1;
            delay   = $urandom % 6;  // 1 to 6 cycles in all
            o_count = o_count + 1;
        end
    end

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`default_nettype none

`include "icache_defines.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]           addr;
        logic [63:0]           data;
        icache_pkg::exc_code_e exc;
        logic                  fast;     // hit or address error
        logic [31:0]           acc_cyc;
    } expect_t;

    logic                      clk;
    logic                      rstn;
    logic                      i_rvalid;
    logic [`ICACHE_ADDR_W-1:0] i_raddr;
    logic                      i_uncache;
    logic                      i_flush;
    logic                      o_rready;
    logic [63:0]               o_rdata;
    logic [`ICACHE_ADDR_W-1:0] o_pc;
    icache_pkg::exc_code_e     o_exception;
    logic [`ICACHE_ADDR_W-1:0] o_badv;
    logic                      o_idle;
    logic                      i_cacop_en;
    icache_pkg::cacop_e        i_cacop_code;
    logic                      o_cacop_done;
    logic                      o_mem_rvalid;
    logic [`ICACHE_ADDR_W-1:0] o_mem_raddr;
    logic                      i_mem_rready;
    logic [`ICACHE_LINE_W-1:0] i_mem_rdata;
    int                        mem_count;

    // reference copy of tags, valid bits and most recently used way
    logic [`ICACHE_TAG_W-1:0] ref_tag [2][16];
    logic [15:0]              ref_valid [2];
    logic [15:0]              ref_mru;
    int                       exp_mem = 0;
    logic [31:0]              cyc = 0;
    string                    test_name = "reset";
    expect_t                  exp_q [$];

    icache_top DUT (.*);

    icache_mem_model u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .i_rvalid (o_mem_rvalid),
        .i_raddr  (o_mem_raddr),
        .o_rready (i_mem_rready),
        .o_rdata  (i_mem_rdata),
        .o_count  (mem_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [3:0] idx_of(input logic [31:0] a);
        return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic logic [`ICACHE_TAG_W-1:0] tag_of(input logic [31:0] a);
        return a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
    endfunction

    // expected doubleword with the low word at the lower address
    function automatic logic [63:0] expected_dword(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    function automatic logic predict_hit(input logic [31:0] a, output logic way);
        logic [1:0] hit;
        hit[0] = ref_valid[0][idx_of(a)] && (ref_tag[0][idx_of(a)] == tag_of(a));
        hit[1] = ref_valid[1][idx_of(a)] && (ref_tag[1][idx_of(a)] == tag_of(a));
        way = hit[1];
        return |hit;
    endfunction

    function automatic void update_model(input logic [31:0] a, input logic unc);
        logic way;
        logic hit;
        hit = predict_hit(a, way);
        if (unc) begin
            exp_mem++;  // never allocates
        end else if (hit) begin
            ref_mru[idx_of(a)] = way;
        end else begin
            way = ~ref_mru[idx_of(a)];
            ref_tag[way][idx_of(a)]   = tag_of(a);
            ref_valid[way][idx_of(a)] = 1'b1;
            ref_mru[idx_of(a)]        = way;
            exp_mem++;
        end
    endfunction

    // answer expected for a fetch accepted at the last edge
    function automatic expect_t predict_answer(input logic [31:0] addr, input logic unc);
        expect_t e;
        logic    way;
        e.addr    = addr;
        e.data    = expected_dword(addr);
        e.acc_cyc = cyc;
        e.exc     = (addr[1:0] != 2'b00) ? icache_pkg::EXC_ADEF : icache_pkg::EXC_NONE;
        e.fast    = (e.exc != icache_pkg::EXC_NONE) || (!unc && predict_hit(addr, way));
        if (e.exc == icache_pkg::EXC_NONE) update_model(addr, unc);
        return e;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s %s: expected %h, actual %h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_exc(input string what, input icache_pkg::exc_code_e exp,
                             input icache_pkg::exc_code_e act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s %s: expected %s, actual %s (%h)",
                                    test_name, what, exp.name(), act.name(), act));
        end
    endtask

    task automatic check_addr(input string what, input logic [`ICACHE_ADDR_W-1:0] exp,
                              input logic [`ICACHE_ADDR_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s %s: expected %h, actual %h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_mem_count(input string what, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (!o_idle) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 40) stop_on_error({test_name, ": cache never went idle ", what});
        end
    endtask

    task automatic wait_answers(input logic [31:0] addr);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 40) begin
                stop_on_error($sformatf("%s: no o_rready for fetch of %h", test_name, addr));
            end
        end
        check_mem_count("memory requests", exp_mem, mem_count);
    endtask

    task automatic fetch(input logic [31:0] addr, input logic unc);
        wait_idle("before a fetch");
        i_raddr   = addr;
        i_uncache = unc;
        i_rvalid  = 1'b1;
        @(posedge clk);  // accepted here
        #1;
        i_rvalid  = 1'b0;
        exp_q.push_back(predict_answer(addr, unc));
        wait_answers(addr);
    endtask

    // second fetch offered while the first one answers as a hit
    task automatic hit_pair(input logic [31:0] addr_a, input logic [31:0] addr_b);
        wait_idle("before a hit pair");
        i_raddr   = addr_a;
        i_uncache = 1'b0;
        i_rvalid  = 1'b1;
        @(posedge clk);
        #1;
        exp_q.push_back(predict_answer(addr_a, 1'b0));
        i_raddr   = addr_b;
        @(posedge clk);  // taken in the answer cycle
        #1;
        i_rvalid  = 1'b0;
        exp_q.push_back(predict_answer(addr_b, 1'b0));
        wait_answers(addr_b);
    endtask

    task automatic cache_op(input icache_pkg::cacop_e code, input logic [31:0] addr);
        logic way;
        logic hit;
        hit = predict_hit(addr, way);
        wait_idle("before a cache operation");
        i_raddr      = addr;
        i_cacop_code = code;
        i_cacop_en   = 1'b1;
        @(posedge clk);
        #1;
        i_cacop_en   = 1'b0;
        @(negedge clk);
        if (!o_cacop_done) stop_on_error({test_name, ": o_cacop_done missing after acceptance"});
        if (code != icache_pkg::CACOP_HIT_INV) begin
            ref_valid[addr[0]][idx_of(addr)] = 1'b0;  // way named by bit 0
        end else if (hit) begin
            ref_valid[way][idx_of(addr)] = 1'b0;
        end
        @(posedge clk);
        #1;
        if (o_cacop_done) stop_on_error({test_name, ": o_cacop_done longer than one cycle"});
    endtask

    // cold miss cancelled while memory is busy but the refill still lands
    task automatic flushed_fetch(input logic [31:0] addr);
        int n;
        wait_idle("before a flushed fetch");
        i_raddr   = addr;
        i_uncache = 1'b0;
        i_rvalid  = 1'b1;
        @(posedge clk);
        #1;
        i_rvalid  = 1'b0;
        update_model(addr, 1'b0);
        n = 0;
        while (!o_mem_rvalid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 10) stop_on_error({test_name, ": memory request never started"});
        end
        i_flush = 1'b1;
        @(posedge clk);
        #1;
        i_flush = 1'b0;
        wait_idle("after a flushed refill");
        check_mem_count("memory requests", exp_mem, mem_count);
    endtask

    // each answer against the oldest outstanding fetch
    always @(negedge clk) begin
        expect_t e;
        if (rstn && o_rready) begin
            if (exp_q.size() == 0) begin
                stop_on_error({test_name, ": o_rready with no fetch outstanding"});
            end else begin
                e = exp_q.pop_front();
                check_addr("o_pc", e.addr, o_pc);
                check_exc("o_exception", e.exc, o_exception);
                check_addr("o_badv", (e.exc != icache_pkg::EXC_NONE) ? e.addr : 32'h0, o_badv);
                if (e.exc == icache_pkg::EXC_NONE) check_data("o_rdata", e.data, o_rdata);
                if (e.fast && cyc != e.acc_cyc) begin
                    stop_on_error($sformatf("%s: answer for %h was not one cycle after acceptance",
                                            test_name, e.addr));
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        void'($urandom(32'hdd96));
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_uncache    = 1'b0;
        i_flush      = 1'b0;
        i_cacop_en   = 1'b0;
        i_cacop_code = icache_pkg::CACOP_STORE_TAG;
        ref_valid[0] = '0;
        ref_valid[1] = '0;
        ref_mru      = '0;
        repeat (4) @(posedge clk);
        #1;
        if (o_rready || o_mem_rvalid || o_cacop_done || !o_idle) begin
            stop_on_error("outputs are not at their reset values during reset");
        end
        rstn = 1'b1;

        test_name = "miss_then_hit";
        fetch(32'h0000_1020, 1'b0);
        fetch(32'h0000_1028, 1'b0);
        fetch(32'h0000_1024, 1'b0);
        hit_pair(32'h0000_1028, 32'h0000_1020);

        test_name = "lru_replacement";  // three tags in set 5
        fetch(32'h0000_2050, 1'b0);
        fetch(32'h0000_3058, 1'b0);
        fetch(32'h0000_2050, 1'b0);
        fetch(32'h0000_4050, 1'b0);
        fetch(32'h0000_2058, 1'b0);
        fetch(32'h0000_3050, 1'b0);

        test_name = "uncached";
        fetch(32'h0000_5060, 1'b1);
        fetch(32'h0000_5068, 1'b1);
        fetch(32'h0000_5060, 1'b0);

        test_name = "misaligned";
        fetch(32'h0000_6071, 1'b0);
        fetch(32'h0000_6076, 1'b1);

        test_name = "cache_ops";
        cache_op(icache_pkg::CACOP_INDEX_INV, 32'h0000_0020);
        cache_op(icache_pkg::CACOP_INDEX_INV, 32'h0000_0021);
        fetch(32'h0000_1020, 1'b0);
        cache_op(icache_pkg::CACOP_STORE_TAG, 32'h0000_0050);
        cache_op(icache_pkg::CACOP_STORE_TAG, 32'h0000_0051);
        fetch(32'h0000_2050, 1'b0);
        cache_op(icache_pkg::CACOP_HIT_INV, 32'h0000_5060);
        fetch(32'h0000_5060, 1'b0);

        test_name = "flush";
        flushed_fetch(32'h0000_7080);
        fetch(32'h0000_7088, 1'b0);

        test_name = "random";  // four tags over sets 8 to 11
        for (int i = 0; i < 24; i++) begin
            r = $urandom;
            fetch({20'h00010, 2'b00, r[1:0], 2'b10, r[3:2], r[5:4], 2'b00}, r[8:6] == 3'd0);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/icache_pkg.sv
source/icache_if.sv
source/icache_decode.sv
source/icache_execute.sv
source/icache_result.sv
source/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the icache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
